// File: include/cpu_consts.svh
// Fixed sizes and field positions for the 32-bit core; both memories must stay powers of two
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and register file
`define CPU_XLEN        32
`define CPU_REG_BITS    5

// Memory depths in words
`define CPU_IMEM_WORDS  256
`define CPU_DMEM_WORDS  256

`define CPU_PC_STEP     4   // Byte step between instructions

// Instruction field positions
`define CPU_OPC_HI      31
`define CPU_OPC_LO      26
`define CPU_RS_HI       25
`define CPU_RS_LO       21
`define CPU_RT_HI       20
`define CPU_RT_LO       16
`define CPU_RD_HI       15
`define CPU_RD_LO       11
`define CPU_IMM_BITS    16  // Low bits of the word hold the immediate

`endif

// File: design/cpuPkg.sv
// Types for the five-stage core; opcode values must match the words in the loaded programs
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

  typedef logic [`CPU_XLEN-1:0]                word_t;
  typedef logic [`CPU_REG_BITS-1:0]            regIdx_t;
  typedef logic [$clog2(`CPU_IMEM_WORDS)-1:0]  imemIdx_t;

  // ********************************************************************
  // Encodings
  // ********************************************************************

  typedef enum logic [`CPU_OPC_HI-`CPU_OPC_LO:0] {
    opNop  = 6'b000000,
    opAdd  = 6'b000001,
    opSub  = 6'b000010,
    opAnd  = 6'b000101,
    opOr   = 6'b000110,
    opNor  = 6'b000111,
    opXor  = 6'b001000,
    opSll  = 6'b001010,
    opSra  = 6'b001011,
    opSrl  = 6'b001100,
    opAddi = 6'b100000,
    opSubi = 6'b100001,
    opLd   = 6'b100100,
    opSt   = 6'b100101,
    opBeq  = 6'b101000,
    opBne  = 6'b101001,
    opJmp  = 6'b101010
  } opcode_e;

  typedef enum logic [3:0] {
    aluPass = 4'b0000,
    aluAdd  = 4'b0001,
    aluSub  = 4'b0010,
    aluAnd  = 4'b0100,
    aluOr   = 4'b0101,
    aluNor  = 4'b0110,
    aluXor  = 4'b0111,
    aluSll  = 4'b1001,
    aluSra  = 4'b1010,
    aluSrl  = 4'b1011
  } aluOp_e;

  // ********************************************************************
  // Stage payloads
  // ********************************************************************

  typedef struct packed {
    imemIdx_t idx;
    word_t    data;
  } progWord_t;

  typedef struct packed {
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    logic       aluSrc;
    logic       jump;
    logic [1:0] branch;   // Bit 1 is branch, bit 0 selects not-equal
    aluOp_e     aluOp;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pcPlus4;
    logic  valid;
  } ifId_t;

  typedef struct packed {
    ctrl_t   ctrl;
    word_t   rsVal;
    word_t   rtVal;
    word_t   imm;
    word_t   pcPlus4;
    regIdx_t dest;
  } idEx_t;

  typedef struct packed {
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    memToReg;
    word_t   aluResult;
    word_t   storeData;
    regIdx_t dest;
  } exMem_t;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    word_t   aluResult;
    word_t   memWord;
    regIdx_t dest;
  } memWb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    regIdx_t dest;
    word_t   data;
  } commit_t;

endpackage

`default_nettype wire

// File: design/fetchStage.sv
// Program words are taken only while rst is high; the PC index wraps inside the instruction memory
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetchStage (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    progWrite,
  input  wire cpuPkg::progWord_t prog,
  input  wire                    stall,
  input  wire                    flush,
  input  wire                    freeze,
  input  wire cpuPkg::redirect_t redirect,
  output cpuPkg::ifId_t          ifId
);

  import cpuPkg::*;

  localparam int PcShift = $clog2(`CPU_PC_STEP);

  word_t    imem [`CPU_IMEM_WORDS];
  word_t    pc;
  word_t    pcPlus4;
  word_t    nextPc;
  imemIdx_t fetchIdx;

  assign fetchIdx = pc[PcShift +: $bits(imemIdx_t)];  // Byte PC to word index
  assign pcPlus4  = pc + word_t'(`CPU_PC_STEP);
  assign nextPc   = redirect.taken ? redirect.target : pcPlus4;

  // Program load port
  always_ff @(posedge clk) begin
    if (rst && progWrite) begin
      imem[prog.idx] <= prog.data;
    end
  end

  // PC and fetch/decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= '0;
      ifId.valid <= 1'b0;
    end else if (!freeze) begin
      if (flush) begin
        pc         <= nextPc;       // Redirect target
        ifId.valid <= 1'b0;         // Squash the younger fetch
      end else if (!stall) begin
        pc           <= nextPc;
        ifId.instr   <= imem[fetchIdx];
        ifId.pcPlus4 <= pcPlus4;
        ifId.valid   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/decodeStage.sv
// Register file writes happen only on a commit transfer; register 0 always reads as zero
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module decodeStage (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  stall,
  input  wire                  flush,
  input  wire                  freeze,
  input  wire cpuPkg::ifId_t   ifId,
  input  wire cpuPkg::commit_t wbWrite,
  input  wire                  wbEnable,
  output cpuPkg::idEx_t        idEx,
  output cpuPkg::regIdx_t      rs,
  output cpuPkg::regIdx_t      rt
);

  import cpuPkg::*;

  opcode_e opcode;
  regIdx_t rsIdx;
  regIdx_t rtIdx;
  regIdx_t rdIdx;
  regIdx_t dest;
  ctrl_t   ctrl;
  logic    destFromRt;
  logic    rfWrite;
  word_t   regs [2**`CPU_REG_BITS];
  word_t   rsVal;
  word_t   rtVal;
  word_t   imm;

  assign opcode = opcode_e'(ifId.instr[`CPU_OPC_HI:`CPU_OPC_LO]);
  assign rsIdx  = ifId.instr[`CPU_RS_HI:`CPU_RS_LO];
  assign rtIdx  = ifId.instr[`CPU_RT_HI:`CPU_RT_LO];
  assign rdIdx  = ifId.instr[`CPU_RD_HI:`CPU_RD_LO];
  assign imm    = {{(`CPU_XLEN-`CPU_IMM_BITS){ifId.instr[`CPU_IMM_BITS-1]}},
                   ifId.instr[`CPU_IMM_BITS-1:0]};

  // Hazard sources are zero for a bubble
  assign rs = ifId.valid ? rsIdx : '0;
  assign rt = ifId.valid ? rtIdx : '0;

  // ********************************************************************
  // Decoder table
  // ********************************************************************
  always_comb begin
    ctrl       = '0;
    destFromRt = 1'b0;
    case (opcode)
      opAdd, opSub, opAnd, opOr, opNor, opXor, opSll, opSrl, opSra: begin
        ctrl.regWrite = 1'b1;
      end
      opAddi, opSubi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        destFromRt    = 1'b1;
      end
      opLd: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        destFromRt    = 1'b1;
      end
      opSt: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        destFromRt    = 1'b1;
      end
      opBeq:   ctrl.branch = 2'b10;
      opBne:   ctrl.branch = 2'b11;
      opJmp:   ctrl.jump   = 1'b1;
      default: ctrl        = '0;     // NOP and unknown opcodes
    endcase
    case (opcode)
      opAdd, opAddi, opLd, opSt: ctrl.aluOp = aluAdd;   // Loads and stores add the offset
      opSub, opSubi, opBeq, opBne: ctrl.aluOp = aluSub;
      opAnd:   ctrl.aluOp = aluAnd;
      opOr:    ctrl.aluOp = aluOr;
      opNor:   ctrl.aluOp = aluNor;
      opXor:   ctrl.aluOp = aluXor;
      opSll:   ctrl.aluOp = aluSll;
      opSrl:   ctrl.aluOp = aluSrl;
      opSra:   ctrl.aluOp = aluSra;
      default: ctrl.aluOp = aluPass;
    endcase
    dest = destFromRt ? rtIdx : rdIdx;
    if (dest == '0) begin
      ctrl.regWrite = 1'b0;          // Writes to register 0 are dropped here
    end
    if (!ifId.valid) begin
      ctrl = '0;
    end
  end

  // ********************************************************************
  // Register file with write-through read
  // ********************************************************************
  assign rfWrite = wbEnable && !freeze && (wbWrite.dest != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`CPU_REG_BITS; i++) begin
        regs[i] <= '0;
      end
    end else if (rfWrite) begin
      regs[wbWrite.dest] <= wbWrite.data;
    end
  end

  assign rsVal = (rfWrite && wbWrite.dest == rsIdx) ? wbWrite.data : regs[rsIdx];
  assign rtVal = (rfWrite && wbWrite.dest == rtIdx) ? wbWrite.data : regs[rtIdx];

  // Decode/execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.ctrl <= '0;
    end else if (!freeze) begin
      if (flush || stall) begin
        idEx.ctrl <= '0;             // Bubble
      end else begin
        idEx.ctrl    <= ctrl;
        idEx.rsVal   <= rsVal;
        idEx.rtVal   <= rtVal;
        idEx.imm     <= imm;
        idEx.pcPlus4 <= ifId.pcPlus4;
        idEx.dest    <= dest;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/executeStage.sv
// Branch and jump targets are PC relative or absolute word offsets; shifts use the low 5 bits
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module executeStage (
  input  wire                clk,
  input  wire                rst,
  input  wire                freeze,
  input  wire cpuPkg::idEx_t idEx,
  output cpuPkg::exMem_t     exMem,
  output cpuPkg::redirect_t  redirect
);

  import cpuPkg::*;

  localparam int ShiftBits = $clog2(`CPU_XLEN);
  localparam int PcShift   = $clog2(`CPU_PC_STEP);

  word_t                opA;
  word_t                opB;
  word_t                aluResult;
  logic [ShiftBits-1:0] shamt;
  logic                 operandsEqual;
  logic                 branchTaken;

  assign opA   = idEx.rsVal;
  assign opB   = idEx.ctrl.aluSrc ? idEx.imm : idEx.rtVal;
  assign shamt = opB[ShiftBits-1:0];

  // ********************************************************************
  // ALU
  // ********************************************************************
  always_comb begin
    case (idEx.ctrl.aluOp)
      aluAdd:  aluResult = opA + opB;
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      aluNor:  aluResult = ~(opA | opB);
      aluXor:  aluResult = opA ^ opB;
      aluSll:  aluResult = opA << shamt;
      aluSrl:  aluResult = opA >> shamt;
      aluSra:  aluResult = word_t'($signed(opA) >>> shamt);
      aluPass: aluResult = opB;
      default: aluResult = '0;
    endcase
  end

  // Branch resolution
  assign operandsEqual = (opA == idEx.rtVal);
  assign branchTaken   = idEx.ctrl.branch[1] & (idEx.ctrl.branch[0] ^ operandsEqual);

  assign redirect.taken  = (branchTaken | idEx.ctrl.jump) & ~freeze;
  assign redirect.target = idEx.ctrl.jump ? (idEx.imm << PcShift)
                                          : (idEx.pcPlus4 + (idEx.imm << PcShift));

  // Execute/memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.memToReg <= 1'b0;
    end else if (!freeze) begin
      exMem.regWrite  <= idEx.ctrl.regWrite;
      exMem.memRead   <= idEx.ctrl.memRead;
      exMem.memWrite  <= idEx.ctrl.memWrite;
      exMem.memToReg  <= idEx.ctrl.memToReg;
      exMem.aluResult <= aluResult;
      exMem.storeData <= idEx.rtVal;
      exMem.dest      <= idEx.dest;
    end
  end

endmodule

`default_nettype wire

// File: design/memoryStage.sv
// Data memory is word addressed by the low ALU result bits and has no reset
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module memoryStage (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 freeze,
  input  wire cpuPkg::exMem_t exMem,
  output cpuPkg::commit_t     wbWrite,
  output logic                wbEnable,
  output logic                commitValid,
  output cpuPkg::commit_t     commit
);

  import cpuPkg::*;

  localparam int DmemBits = $clog2(`CPU_DMEM_WORDS);

  word_t               dmem [`CPU_DMEM_WORDS];
  logic [DmemBits-1:0] dmemIdx;
  word_t               memWord;
  memWb_t              memWb;

  assign dmemIdx = exMem.aluResult[DmemBits-1:0];
  assign memWord = exMem.memRead ? dmem[dmemIdx] : '0;

  always_ff @(posedge clk) begin
    if (exMem.memWrite && !freeze) begin
      dmem[dmemIdx] <= exMem.storeData;
    end
  end

  // Memory/writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.regWrite <= 1'b0;
    end else if (!freeze) begin
      memWb.regWrite  <= exMem.regWrite;
      memWb.memToReg  <= exMem.memToReg;
      memWb.aluResult <= exMem.aluResult;
      memWb.memWord   <= memWord;
      memWb.dest      <= exMem.dest;
    end
  end

  // Writeback select feeds both the register file and the commit stream
  assign wbWrite.dest = memWb.dest;
  assign wbWrite.data = memWb.memToReg ? memWb.memWord : memWb.aluResult;
  assign wbEnable     = memWb.regWrite;
  assign commitValid  = memWb.regWrite;
  assign commit       = wbWrite;

endmodule

`default_nettype wire

// File: design/pipelineControl.sv
// No forwarding; any source matching a pending write in execute or memory stalls decode
`timescale 1ns/1ps
`default_nettype none

module pipelineControl (
  input  wire cpuPkg::regIdx_t   rs,
  input  wire cpuPkg::regIdx_t   rt,
  input  wire cpuPkg::regIdx_t   exDest,
  input  wire cpuPkg::regIdx_t   memDest,
  input  wire                    exRegWrite,
  input  wire                    memRegWrite,
  input  wire cpuPkg::redirect_t redirect,
  input  wire                    commitValid,
  input  wire                    commitReady,
  output logic                   stall,
  output logic                   flush,
  output logic                   freeze
);

  import cpuPkg::*;

  logic hazard;

  // Source waits on an older producer still in flight
  function automatic logic dependsOn(input regIdx_t src, input regIdx_t exD,
                                     input regIdx_t memD, input logic exW,
                                     input logic memW);
    logic match;
    match = (exW && src == exD) || (memW && src == memD);
    return (src != '0) && match;
  endfunction

  assign hazard = dependsOn(rs, exDest, memDest, exRegWrite, memRegWrite) ||
                  dependsOn(rt, exDest, memDest, exRegWrite, memRegWrite);

  // Freeze over flush over stall
  assign freeze = commitValid & ~commitReady;
  assign flush  = redirect.taken & ~freeze;
  assign stall  = hazard & ~flush & ~freeze;

endmodule

`default_nettype wire

// File: design/cpuTop.sv
// Load the program while rst is high; a stalled commit stream freezes the whole pipeline
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    progWrite,
  input  wire cpuPkg::progWord_t prog,
  output logic                   commitValid,
  input  wire                    commitReady,
  output cpuPkg::commit_t        commit
);

  import cpuPkg::*;

  ifId_t     ifId;
  idEx_t     idEx;
  exMem_t    exMem;
  redirect_t redirect;
  regIdx_t   rs;
  regIdx_t   rt;
  commit_t   wbWrite;
  logic      wbEnable;
  logic      stall;
  logic      flush;
  logic      freeze;

  // ********************************************************************
  // Pipeline stages
  // ********************************************************************
  fetchStage fetchStage_i (
    .clk       (clk),
    .rst       (rst),
    .progWrite (progWrite),
    .prog      (prog),
    .stall     (stall),
    .flush     (flush),
    .freeze    (freeze),
    .redirect  (redirect),
    .ifId      (ifId)
  );

  decodeStage decodeStage_i (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .flush    (flush),
    .freeze   (freeze),     // Also holds the register file write
    .ifId     (ifId),
    .wbWrite  (wbWrite),
    .wbEnable (wbEnable),
    .idEx     (idEx),
    .rs       (rs),
    .rt       (rt)
  );

  executeStage executeStage_i (
    .clk      (clk),
    .rst      (rst),
    .freeze   (freeze),
    .idEx     (idEx),
    .exMem    (exMem),
    .redirect (redirect)
  );

  memoryStage memoryStage_i (
    .clk         (clk),
    .rst         (rst),
    .freeze      (freeze),
    .exMem       (exMem),
    .wbWrite     (wbWrite),
    .wbEnable    (wbEnable),
    .commitValid (commitValid),
    .commit      (commit)
  );

  // Hazard, redirect and back-pressure control
  pipelineControl pipelineControl_i (
    .rs          (rs),
    .rt          (rt),
    .exDest      (idEx.dest),
    .memDest     (exMem.dest),
    .exRegWrite  (idEx.ctrl.regWrite),
    .memRegWrite (exMem.regWrite),
    .redirect    (redirect),
    .commitValid (commitValid),
    .commitReady (commitReady),
    .stall       (stall),
    .flush       (flush),
    .freeze      (freeze)
  );

endmodule

`default_nettype wire

// File: testbench/cpuTop_checker.sv
// Commit stream checks bound into the top level; only meaningful once clk is running
`timescale 1ns/1ps
`default_nettype none

module cpuTop_checker (
  input wire                  clk,
  input wire                  rst,
  input wire                  commitValid,
  input wire                  commitReady,
  input wire cpuPkg::commit_t commit
);

  int failCount = 0;   // Failed assertions so far

  // ********************************************************************
  // Reset behaviour
  // ********************************************************************
  // Registers are cleared by the first reset edge, so look one cycle in
  noValidInReset: assert property (@(posedge clk) rst && $past(rst) |-> !commitValid)
    else begin
      $error("commitValid high while reset is held");
      failCount++;
    end

  // ********************************************************************
  // Commit handshake
  // ********************************************************************
  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
    commitValid && !commitReady |=> commitValid && $stable(commit))
    else begin
      $error("Stalled commit dropped valid or changed its payload");
      failCount++;
    end

  noZeroDest: assert property (@(posedge clk) disable iff (rst)
    commitValid |-> commit.dest != '0)
    else begin
      $error("Commit reported a write to register 0");
      failCount++;
    end

endmodule

bind cpuTop cpuTop_checker cpuTop_checker_i (.*);

`default_nettype wire

// File: testbench/cpuTb.sv
// Needs testbench/cpuStim.txt relative to the run directory; each program must end in a self jump
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuTb;

  import cpuPkg::*;

  localparam int ResetCycles = 8;

  logic      clk;
  logic      rst;
  logic      progWrite;
  progWord_t prog;
  logic      commitReady;
  logic      commitValid;
  commit_t   commit;

  // Parsed stimulus with one entry per line of the file
  string     testName[$];
  int        progTest[$];
  imemIdx_t  progIdx[$];
  word_t     progData[$];
  int        expTest[$];
  regIdx_t   expReg[$];
  word_t     expData[$];

  int        cycles;
  int        cycleLimit;
  int        errors;
  int        testsOk;
  int        testsBad;
  logic      stimOk;

  cpuTop cpuTop_i (
    .clk         (clk),
    .rst         (rst),
    .progWrite   (progWrite),
    .prog        (prog),
    .commitValid (commitValid),
    .commitReady (commitReady),
    .commit      (commit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit is armed once the stimulus is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: no progress after %0d cycles, commits are missing", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // ********************************************************************
  // Stimulus file reader
  // ********************************************************************
  task automatic readStim(output logic ok);
    int          fd;
    int          n;
    string       line;
    string       tag;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    ok = 1'b1;
    fd = $fopen("testbench/cpuStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file testbench/cpuStim.txt");
      ok = 1'b0;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s", tag);
      if (n < 1 || tag.substr(0, 0) == "#") begin
        continue;                                   // Blank or comment
      end
      if (tag == "T") begin
        n = $sscanf(line, "%s %s", tag, name);
        testName.push_back(name);
      end else if (testName.size() == 0) begin
        $display("Stimulus line before any test name: %s", line);
        ok = 1'b0;
      end else if (tag == "P") begin
        n = $sscanf(line, "%s %h %h", tag, a, b);
        progTest.push_back(testName.size() - 1);
        progIdx.push_back(imemIdx_t'(a));
        progData.push_back(b);
      end else if (tag == "E") begin
        n = $sscanf(line, "%s %h %h", tag, a, b);
        expTest.push_back(testName.size() - 1);
        expReg.push_back(regIdx_t'(a));
        expData.push_back(b);
      end else begin
        $display("Unknown line in stimulus file: %s", line);
        ok = 1'b0;
      end
    end
    $fclose(fd);
    if (testName.size() == 0) begin
      $display("Stimulus file holds no tests");
      ok = 1'b0;
    end
  endtask

  // ********************************************************************
  // One test loads during reset and then collects commits
  // ********************************************************************
  task automatic runTest(input int t);
    imemIdx_t wIdx[$];
    word_t    wData[$];
    regIdx_t  eReg[$];
    word_t    eData[$];
    int       p;
    int       k;
    int       count;
    int       errsBefore;
    for (int i = 0; i < progTest.size(); i++) begin
      if (progTest[i] == t) begin
        wIdx.push_back(progIdx[i]);
        wData.push_back(progData[i]);
      end
    end
    for (int i = 0; i < expTest.size(); i++) begin
      if (expTest[i] == t) begin
        eReg.push_back(expReg[i]);
        eData.push_back(expData[i]);
      end
    end
    errsBefore = errors;

    @(posedge clk);
    rst         <= 1'b1;
    progWrite   <= 1'b0;
    commitReady <= 1'b1;
    p = 0;
    k = 0;
    // Reset stays high for at least 8 cycles and until the program is in
    while (k < ResetCycles || p < wIdx.size()) begin
      if (p < wIdx.size()) begin
        progWrite <= 1'b1;
        prog      <= '{idx: wIdx[p], data: wData[p]};
        p++;
      end else begin
        progWrite <= 1'b0;
      end
      @(posedge clk);
      k++;
    end
    progWrite   <= 1'b0;
    rst         <= 1'b0;
    commitReady <= ($urandom % 4) != 0;

    count = 0;
    while (count < eReg.size()) begin
      @(negedge clk);                               // Handshake is settled here
      if (commitValid && commitReady) begin
        assert (commit.dest == eReg[count] && commit.data == eData[count])
          else begin
            $display("CHECK FAILED %s commit %0d: expected r%0d=%h, actual r%0d=%h",
                     testName[t], count, eReg[count], eData[count], commit.dest, commit.data);
            errors++;
          end
        count++;
      end
      @(posedge clk);
      commitReady <= ($urandom % 4) != 0;           // About one cycle in four stalls
    end

    if (errors == errsBefore) begin
      testsOk++;
      $display("Test %s: %0d commits ok", testName[t], count);
    end else begin
      testsBad++;
      $display("Test %s: %0d commits, %0d mismatches", testName[t], count,
               errors - errsBefore);
    end
  endtask

  // ********************************************************************
  // Main sequence
  // ********************************************************************
  initial begin
    rst         = 1'b1;
    progWrite   = 1'b0;
    prog        = '0;
    commitReady = 1'b0;
    cycles      = 0;
    cycleLimit  = 0;
    errors      = 0;
    testsOk     = 0;
    testsBad    = 0;
    void'($urandom(32'haaa));

    readStim(stimOk);
    if (stimOk) begin
      cycleLimit = 8 * expData.size() + 200;
      for (int t = 0; t < testName.size(); t++) begin
        runTest(t);
      end
    end else begin
      errors++;
    end

    $display("Tests run: %0d, ok: %0d, failing: %0d, check errors: %0d, assertion errors: %0d",
             testsOk + testsBad, testsOk, testsBad, errors,
             cpuTop_i.cpuTop_checker_i.failCount);
    if (errors == 0 && cpuTop_i.cpuTop_checker_i.failCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/cpuStim.txt
# T <name> starts a test; P <imem index> <instruction word> loads a word (hex)
# E <register> <value> is the next expected commit in program order (hex)
T alu
P 00 8001000C
P 01 8002FFFD
P 02 04221800
P 03 08222000
P 04 14222800
P 05 18223000
P 06 1C223800
P 07 20224000
P 08 80090004
P 09 28495000
P 0A 30495800
P 0B 2C496000
P 0C 842D0014
P 0D A800000D
E 01 0000000C
E 02 FFFFFFFD
E 03 00000009
E 04 0000000F
E 05 0000000C
E 06 FFFFFFFD
E 07 00000002
E 08 FFFFFFF1
E 09 00000004
E 0A FFFFFFD0
E 0B 0FFFFFFF
E 0C FFFFFFFF
E 0D FFFFFFF8
T raw
P 00 80010005
P 01 04211000
P 02 04411800
P 03 84640001
P 04 04832800
P 05 A8000005
E 01 00000005
E 02 0000000A
E 03 0000000F
E 04 0000000E
E 05 0000001D
T mem
P 00 80011234
P 01 80020007
P 02 94410003
P 03 90430003
P 04 04632000
P 05 A8000005
E 01 00001234
E 02 00000007
E 03 00001234
E 04 00002468
T branch
P 00 80010001
P 01 80020001
P 02 A4220002
P 03 80030003
P 04 A0220001
P 05 80040004
P 06 A8000008
P 07 80050005
P 08 80060006
P 09 A8000009
E 01 00000001
E 02 00000001
E 03 00000003
E 06 00000006
T fib
P 00 80010000
P 01 80020001
P 02 80040004
P 03 04221800
P 04 04400800
P 05 04601000
P 06 84840001
P 07 A480FFFB
P 08 A8000008
E 01 00000000
E 02 00000001
E 04 00000004
E 03 00000001
E 01 00000001
E 02 00000001
E 04 00000003
E 03 00000002
E 01 00000001
E 02 00000002
E 04 00000002
E 03 00000003
E 01 00000002
E 02 00000003
E 04 00000001
E 03 00000005
E 01 00000003
E 02 00000005
E 04 00000000
T zero
P 00 80000005
P 01 80010009
P 02 04210000
P 03 18001000
P 04 04201800
P 05 A8000005
E 01 00000009
E 02 00000000
E 03 00000009

// File: all.f
+incdir+include
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineControl.sv
design/cpuTop.sv
testbench/cpuTop_checker.sv
testbench/cpuTb.sv
